//--- hw/carry_sum_gen.sv
`timescale 1ns/1ns

module carry_sum_gen (
    input  logic [6:0] bits_in,
    output logic [2:0] carries,
    output logic       sum_bit
);

    // lower group of four, upper group of three
    logic [3:0] grp_lo;
    logic [2:0] grp_hi;
    // per-group counts, 0..4 and 0..3
    logic [2:0] cnt_lo;
    logic [1:0] cnt_hi;

    assign {grp_hi, grp_lo} = bits_in;

    assign cnt_lo = {2'b00, grp_lo[0]} + {2'b00, grp_lo[1]}
                  + {2'b00, grp_lo[2]} + {2'b00, grp_lo[3]};
    assign cnt_hi = {1'b0, grp_hi[0]} + {1'b0, grp_hi[1]} + {1'b0, grp_hi[2]};

    // parity of the whole input
    assign sum_bit = cnt_lo[0] ^ cnt_hi[0];

    // a: at least two ones in the lower group
    assign carries[2] = (cnt_lo > 3'd1);
    // b: at least two ones in the upper group
    assign carries[1] = (cnt_hi > 2'd1);
    // c: lower group full, or both groups odd
    assign carries[0] = (cnt_lo == 3'd4) | (cnt_lo[0] & cnt_hi[0]);

    // net effect: 2*(a+b+c) + sum_bit equals the number of set bits

endmodule

//--- hw/count_stage.sv
`timescale 1ns/1ns

module count_stage #(
    parameter int NUM_PORTS = occ_select_pkg::MAX_PORTS
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      in_valid,
    input  logic [NUM_PORTS-1:0]                      eligible,
    input  logic [NUM_PORTS*occ_select_pkg::OCC_W-1:0] occupancy,
    output logic                                      s1_valid,
    output logic [NUM_PORTS-1:0]                      s1_eligible,
    output logic [NUM_PORTS*occ_select_pkg::OCC_W-1:0] s1_occupancy,
    output occ_select_pkg::count_t                    s1_count
);

    // mask widened to the counter's fixed input
    logic [occ_select_pkg::MAX_PORTS-1:0] mask_ext;
    occ_select_pkg::count_t               elig_count;

    generate
        if (NUM_PORTS < occ_select_pkg::MAX_PORTS) begin : g_pad
            assign mask_ext = {{(occ_select_pkg::MAX_PORTS-NUM_PORTS){1'b0}}, eligible};
        end else begin : g_full
            assign mask_ext = eligible;
        end
    endgenerate

    popcount_15 u_popcount (
        .bits_in (mask_ext),
        .count   (elig_count)
    );

    // strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // payload only loads on a request
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_eligible  <= eligible;
            s1_occupancy <= occupancy;
            s1_count     <= elig_count;
        end
    end

endmodule

//--- hw/encode_stage.sv
`timescale 1ns/1ns

module encode_stage #(
    parameter int NUM_PORTS = occ_select_pkg::MAX_PORTS
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      s2_valid,
    input  logic [NUM_PORTS-1:0]                      s2_min_onehot,
    input  logic [NUM_PORTS-1:0]                      s2_eligible,
    input  logic [NUM_PORTS*occ_select_pkg::OCC_W-1:0] s2_occupancy,
    input  occ_select_pkg::count_t                    s2_count,
    output logic                                      out_valid,
    output logic                                      grant_valid,
    output occ_select_pkg::index_t                    grant_index,
    output occ_select_pkg::occ_t                      grant_occupancy,
    output occ_select_pkg::count_t                    eligible_count,
    output occ_select_pkg::total_t                    total_occupancy
);

    // raw sum width, always at least one bit wider than the total
    localparam int RAW_W = occ_select_pkg::OCC_W + $clog2(NUM_PORTS);
    localparam int SUM_W = (RAW_W > occ_select_pkg::TOTAL_W) ? RAW_W
                                                             : occ_select_pkg::TOTAL_W + 1;

    occ_select_pkg::occ_t   occ_arr [NUM_PORTS];
    occ_select_pkg::index_t win_index;
    occ_select_pkg::occ_t   win_occ;
    occ_select_pkg::total_t sat_total;
    logic [SUM_W-1:0]       sum;

    // split the flat vector, port 0 in the low field
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            occ_arr[i] = s2_occupancy[i*occ_select_pkg::OCC_W +: occ_select_pkg::OCC_W];
        end
    end

    // one-hot to binary: OR of the index constants masked by their bit
    always_comb begin
        win_index = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            win_index = win_index | ({occ_select_pkg::INDEX_W{s2_min_onehot[i]}}
                                     & occ_select_pkg::index_t'(i));
        end
    end

    // binary mux on the encoded index
    assign win_occ = occ_arr[win_index];

    // sum of eligible occupancies
    always_comb begin
        sum = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (s2_eligible[i]) begin
                sum = sum + SUM_W'(occ_arr[i]);
            end
        end
    end

    // clamp to all ones on overflow
    assign sat_total = (|sum[SUM_W-1:occ_select_pkg::TOTAL_W])
                     ? '1 : sum[occ_select_pkg::TOTAL_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid   <= 1'b0;
            grant_valid <= 1'b0;
        end else begin
            out_valid   <= s2_valid;
            // no eligible port means no grant
            grant_valid <= s2_valid & (s2_count != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            grant_index     <= win_index;
            grant_occupancy <= win_occ;
            eligible_count  <= s2_count;
            total_occupancy <= sat_total;
        end
    end

endmodule

//--- hw/min_stage.sv
`timescale 1ns/1ns

module min_stage #(
    parameter int NUM_PORTS = occ_select_pkg::MAX_PORTS
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      s1_valid,
    input  logic [NUM_PORTS-1:0]                      s1_eligible,
    input  logic [NUM_PORTS*occ_select_pkg::OCC_W-1:0] s1_occupancy,
    input  occ_select_pkg::count_t                    s1_count,
    output logic                                      s2_valid,
    output logic [NUM_PORTS-1:0]                      s2_min_onehot,
    output logic [NUM_PORTS-1:0]                      s2_eligible,
    output logic [NUM_PORTS*occ_select_pkg::OCC_W-1:0] s2_occupancy,
    output occ_select_pkg::count_t                    s2_count
);

    localparam int KEY_W = occ_select_pkg::OCC_W + 1;

    // ineligible flag on top, so those ports compare as larger
    wire [KEY_W-1:0]     key [NUM_PORTS];
    // row i: port i against every other port
    wire [NUM_PORTS-2:0] cmp [NUM_PORTS];
    wire [NUM_PORTS-1:0] min_onehot;

    genvar i, j;
    generate
        for (i = 0; i < NUM_PORTS; i++) begin : g_row
            assign key[i] = {~s1_eligible[i],
                             s1_occupancy[i*occ_select_pkg::OCC_W +: occ_select_pkg::OCC_W]};
            for (j = 0; j < NUM_PORTS-1; j++) begin : g_col
                if (i > j) begin : g_mirror
                    // lower triangle reuses the upper compare, inverted
                    assign cmp[i][j] = ~cmp[j][i-1];
                end else begin : g_cmp
                    // port i vs port j+1, i wins a tie as the lower index
                    assign cmp[i][j] = (key[i] <= key[j+1]);
                end
            end
            // winner beats or ties every other port
            assign min_onehot[i] = &cmp[i];
        end
    endgenerate

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_min_onehot <= min_onehot;
            s2_eligible   <= s1_eligible;
            s2_occupancy  <= s1_occupancy;
            s2_count      <= s1_count;
        end
    end

endmodule

//--- hw/occ_select_pkg.sv
package occ_select_pkg;

    // largest port count the selector supports
    localparam int MAX_PORTS = 15;

    // per-port occupancy width
    localparam int OCC_W = 5;

    // eligible count, holds 0..MAX_PORTS
    localparam int COUNT_W = 4;

    // binary port index
    localparam int INDEX_W = 4;

    // accumulated total, saturates at all ones
    localparam int TOTAL_W = 8;

    // one port's occupancy
    typedef logic [OCC_W-1:0] occ_t;

    // number of eligible ports
    typedef logic [COUNT_W-1:0] count_t;

    // binary index of a port
    typedef logic [INDEX_W-1:0] index_t;

    // saturated occupancy sum
    typedef logic [TOTAL_W-1:0] total_t;

endpackage

//--- hw/occ_select_top.sv
`timescale 1ns/1ns

module occ_select_top #(
    parameter int NUM_PORTS = 15
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      in_valid,
    input  logic [NUM_PORTS-1:0]                      eligible,
    input  logic [NUM_PORTS*occ_select_pkg::OCC_W-1:0] occupancy,
    output logic                                      out_valid,
    output logic                                      grant_valid,
    output occ_select_pkg::index_t                    grant_index,
    output occ_select_pkg::occ_t                      grant_occupancy,
    output occ_select_pkg::count_t                    eligible_count,
    output occ_select_pkg::total_t                    total_occupancy
);

    // stage 1 to stage 2
    logic                                      s1_valid;
    logic [NUM_PORTS-1:0]                      s1_eligible;
    logic [NUM_PORTS*occ_select_pkg::OCC_W-1:0] s1_occupancy;
    occ_select_pkg::count_t                    s1_count;

    // stage 2 to stage 3
    logic                                      s2_valid;
    logic [NUM_PORTS-1:0]                      s2_min_onehot;
    logic [NUM_PORTS-1:0]                      s2_eligible;
    logic [NUM_PORTS*occ_select_pkg::OCC_W-1:0] s2_occupancy;
    occ_select_pkg::count_t                    s2_count;

    // count eligible ports
    count_stage #(.NUM_PORTS(NUM_PORTS)) u_count_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .eligible     (eligible),
        .occupancy    (occupancy),
        .s1_valid     (s1_valid),
        .s1_eligible  (s1_eligible),
        .s1_occupancy (s1_occupancy),
        .s1_count     (s1_count)
    );

    // pick the least-occupied eligible port
    min_stage #(.NUM_PORTS(NUM_PORTS)) u_min_stage (
        .clk           (clk),
        .arst_n        (arst_n),
        .s1_valid      (s1_valid),
        .s1_eligible   (s1_eligible),
        .s1_occupancy  (s1_occupancy),
        .s1_count      (s1_count),
        .s2_valid      (s2_valid),
        .s2_min_onehot (s2_min_onehot),
        .s2_eligible   (s2_eligible),
        .s2_occupancy  (s2_occupancy),
        .s2_count      (s2_count)
    );

    // encode, mux and accumulate
    encode_stage #(.NUM_PORTS(NUM_PORTS)) u_encode_stage (
        .clk             (clk),
        .arst_n          (arst_n),
        .s2_valid        (s2_valid),
        .s2_min_onehot   (s2_min_onehot),
        .s2_eligible     (s2_eligible),
        .s2_occupancy    (s2_occupancy),
        .s2_count        (s2_count),
        .out_valid       (out_valid),
        .grant_valid     (grant_valid),
        .grant_index     (grant_index),
        .grant_occupancy (grant_occupancy),
        .eligible_count  (eligible_count),
        .total_occupancy (total_occupancy)
    );

endmodule

//--- hw/popcount_15.sv
`timescale 1ns/1ns

module popcount_15 (
    input  logic [14:0]                 bits_in,
    output occ_select_pkg::count_t      count
);

    // first level, two carry-sum blocks over bits 0..13
    logic [2:0] carries_a;
    logic [2:0] carries_b;
    logic       sum_a;
    logic       sum_b;
    // weight-2 carry from the leftover sum bits
    logic       extra_carry;
    // second level over all weight-2 terms
    logic [2:0] carries_c;
    logic       sum_c;

    carry_sum_gen u_cs_a (
        .bits_in (bits_in[6:0]),
        .carries (carries_a),
        .sum_bit (sum_a)
    );

    carry_sum_gen u_cs_b (
        .bits_in (bits_in[13:7]),
        .carries (carries_b),
        .sum_bit (sum_b)
    );

    // bit 14 plus both sum bits, 0..3
    assign {extra_carry, count[0]} = {1'b0, bits_in[14]} + {1'b0, sum_a} + {1'b0, sum_b};

    // six carries plus the extra one, all at weight 2
    carry_sum_gen u_cs_c (
        .bits_in ({carries_a, carries_b, extra_carry}),
        .carries (carries_c),
        .sum_bit (sum_c)
    );

    assign count[1] = sum_c;
    // weight-4 carries, at most three of them
    assign count[3:2] = {1'b0, carries_c[0]} + {1'b0, carries_c[1]} + {1'b0, carries_c[2]};

endmodule

//--- occ_select.f
hw/occ_select_pkg.sv
hw/carry_sum_gen.sv
hw/popcount_15.sv
hw/count_stage.sv
hw/min_stage.sv
hw/encode_stage.sv
hw/occ_select_top.sv
testbench/occ_select_tb.sv

//--- testbench/occ_select_tb.sv
`timescale 1ns/1ns

module occ_select_tb;

    localparam int NPORT      = 15;
    localparam int OCC_W      = occ_select_pkg::OCC_W;
    localparam int OCC_BITS   = NPORT * OCC_W;
    localparam int TOTAL_MAX  = (1 << occ_select_pkg::TOTAL_W) - 1;
    localparam int WAIT_LIMIT = 50;

    logic                   clk;
    logic                   arst_n;
    logic                   in_valid;
    logic [NPORT-1:0]       eligible;
    logic [OCC_BITS-1:0]    occupancy;
    logic                   out_valid;
    logic                   grant_valid;
    occ_select_pkg::index_t grant_index;
    occ_select_pkg::occ_t   grant_occupancy;
    occ_select_pkg::count_t eligible_count;
    occ_select_pkg::total_t total_occupancy;

    // requests waiting to be driven
    logic [NPORT-1:0]       req_mask [$];
    logic [OCC_BITS-1:0]    req_occ [$];
    // scoreboard, filled when a request is seen on the inputs
    occ_select_pkg::count_t exp_count [$];
    logic                   exp_grant [$];
    occ_select_pkg::index_t exp_index [$];
    occ_select_pkg::occ_t   exp_occ [$];
    occ_select_pkg::total_t exp_total [$];
    int                     exp_due [$];

    int     cycle = 0;
    int     checks_passed = 0;
    int     checks_failed = 0;
    integer seed;

    occ_select_top #(.NUM_PORTS(NPORT)) u_dut (
        .clk             (clk),
        .arst_n          (arst_n),
        .in_valid        (in_valid),
        .eligible        (eligible),
        .occupancy       (occupancy),
        .out_valid       (out_valid),
        .grant_valid     (grant_valid),
        .grant_index     (grant_index),
        .grant_occupancy (grant_occupancy),
        .eligible_count  (eligible_count),
        .total_occupancy (total_occupancy)
    );

    always #20 clk = ~clk;

    // edge counter, read only at the falling edge
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // reference model of the result rules
    task automatic predict(input logic [NPORT-1:0] mask, input logic [OCC_BITS-1:0] occ);
        occ_select_pkg::count_t cnt;
        occ_select_pkg::index_t best;
        occ_select_pkg::occ_t   best_occ;
        occ_select_pkg::occ_t   val;
        int                     sum;
        logic                   found;
        cnt = '0;
        best = '0;
        best_occ = '0;
        sum = 0;
        found = 1'b0;
        for (int i = 0; i < NPORT; i++) begin
            val = occ[i*OCC_W +: OCC_W];
            if (mask[i]) begin
                cnt = cnt + 1'b1;
                sum = sum + val;
                // strictly smaller only, lowest index keeps a tie
                if (!found || val < best_occ) begin
                    best = occ_select_pkg::index_t'(i);
                    best_occ = val;
                    found = 1'b1;
                end
            end
        end
        exp_count.push_back(cnt);
        exp_grant.push_back(found);
        exp_index.push_back(best);
        exp_occ.push_back(best_occ);
        exp_total.push_back(occ_select_pkg::total_t'((sum > TOTAL_MAX) ? TOTAL_MAX : sum));
        // result shows three cycles after the strobe
        exp_due.push_back(cycle + 3);
    endtask

    // inputs driven at a rising edge are stable here
    always @(negedge clk) begin
        if (arst_n && in_valid) begin
            predict(eligible, occupancy);
        end
    end

    task automatic check_count(input string name, input occ_select_pkg::count_t got,
                               input occ_select_pkg::count_t exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            checks_failed++;
        end else begin
            checks_passed++;
        end
    endtask

    task automatic check_index(input string name, input occ_select_pkg::index_t got,
                               input occ_select_pkg::index_t exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            checks_failed++;
        end else begin
            checks_passed++;
        end
    endtask

    task automatic check_occ(input string name, input occ_select_pkg::occ_t got,
                             input occ_select_pkg::occ_t exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            checks_failed++;
        end else begin
            checks_passed++;
        end
    endtask

    task automatic check_total(input string name, input occ_select_pkg::total_t got,
                               input occ_select_pkg::total_t exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            checks_failed++;
        end else begin
            checks_passed++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            checks_failed++;
        end else begin
            checks_passed++;
        end
    endtask

    // queued requests, optionally with idle cycles between them
    task automatic drive_queued(input bit gaps);
        int n_gap;
        while (req_mask.size() > 0) begin
            @(posedge clk);
            in_valid  <= 1'b1;
            eligible  <= req_mask.pop_front();
            occupancy <= req_occ.pop_front();
            if (gaps) begin
                n_gap = $random(seed) & 7;
                // mostly back to back, sometimes one or two idle cycles
                if (n_gap > 2) begin
                    n_gap = 0;
                end
                repeat (n_gap) begin
                    @(posedge clk);
                    in_valid <= 1'b0;
                end
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic collect_results(input int n);
        int waited;
        int due;
        for (int k = 0; k < n; k++) begin
            waited = 0;
            @(negedge clk);
            while (!out_valid && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!out_valid) begin
                $display("timeout: result %0d of %0d never showed up", k, n);
                checks_failed++;
                exp_count.delete();
                exp_grant.delete();
                exp_index.delete();
                exp_occ.delete();
                exp_total.delete();
                exp_due.delete();
                break;
            end
            if (exp_due.size() == 0) begin
                $display("result at cycle %0d with no request outstanding", cycle);
                checks_failed++;
            end else begin
                due = exp_due.pop_front();
                if (cycle != due) begin
                    $display("result arrived at cycle %0d instead of cycle %0d", cycle, due);
                    checks_failed++;
                end
                check_count("eligible_count", eligible_count, exp_count.pop_front());
                check_total("total_occupancy", total_occupancy, exp_total.pop_front());
                check_flag("grant_valid", grant_valid, exp_grant[0]);
                // index and occupancy only defined with a grant
                if (exp_grant.pop_front()) begin
                    check_index("grant_index", grant_index, exp_index[0]);
                    check_occ("grant_occupancy", grant_occupancy, exp_occ[0]);
                end
                void'(exp_index.pop_front());
                void'(exp_occ.pop_front());
            end
        end
    endtask

    task automatic run_queued(input bit gaps);
        int n;
        n = req_mask.size();
        fork
            drive_queued(gaps);
            collect_results(n);
        join
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("%-12s %s", name, (checks_failed == fails_before) ? "passed" : "FAILED");
    endtask

    function automatic logic [OCC_BITS-1:0] with_field(input logic [OCC_BITS-1:0] vec,
                                                       input int port, input int val);
        vec[port*OCC_W +: OCC_W] = occ_select_pkg::occ_t'(val);
        return vec;
    endfunction

    task automatic random_occ(output logic [OCC_BITS-1:0] vec);
        for (int i = 0; i < NPORT; i++) begin
            vec[i*OCC_W +: OCC_W] = $random(seed);
        end
    endtask

    task automatic test_idle();
        int fails;
        fails = checks_failed;
        repeat (20) begin
            @(negedge clk);
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("grant_valid", grant_valid, 1'b0);
        end
        report_test("idle", fails);
    endtask

    task automatic test_single_port();
        int                  fails;
        logic [OCC_BITS-1:0] occ;
        fails = checks_failed;
        for (int p = 0; p < NPORT; p++) begin
            random_occ(occ);
            req_mask.push_back(NPORT'(1) << p);
            req_occ.push_back(occ);
        end
        run_queued(1'b0);
        report_test("single_port", fails);
    endtask

    task automatic test_ties();
        int                  fails;
        logic [OCC_BITS-1:0] occ;
        fails = checks_failed;
        // ports 0..2 lower but ineligible, tie at 3, 7, 11
        occ = {NPORT{5'd20}};
        occ = with_field(occ, 0, 1);
        occ = with_field(occ, 1, 1);
        occ = with_field(occ, 2, 1);
        occ = with_field(occ, 3, 4);
        occ = with_field(occ, 7, 4);
        occ = with_field(occ, 11, 4);
        occ = with_field(occ, 5, 9);
        req_mask.push_back(15'b000_1000_1010_1000);
        req_occ.push_back(occ);
        // zero tie between 6 and 12, port 2 zero but excluded
        occ = {NPORT{5'd31}};
        occ = with_field(occ, 2, 0);
        occ = with_field(occ, 6, 0);
        occ = with_field(occ, 12, 0);
        req_mask.push_back(15'b101_0000_0101_0000);
        req_occ.push_back(occ);
        run_queued(1'b0);
        report_test("ties", fails);
    endtask

    task automatic test_empty();
        int                  fails;
        logic [OCC_BITS-1:0] occ;
        fails = checks_failed;
        random_occ(occ);
        req_mask.push_back('0);
        req_occ.push_back(occ);
        run_queued(1'b0);
        report_test("empty_mask", fails);
    endtask

    task automatic test_saturation();
        int                  fails;
        logic [OCC_BITS-1:0] occ;
        fails = checks_failed;
        // 15 x 31 clamps to 255
        req_mask.push_back('1);
        req_occ.push_back({NPORT{5'd31}});
        // 15 down to 1, exact sum 120, minimum at the top port
        for (int i = 0; i < NPORT; i++) begin
            occ = with_field(occ, i, NPORT - i);
        end
        req_mask.push_back('1);
        req_occ.push_back(occ);
        run_queued(1'b0);
        report_test("saturation", fails);
    endtask

    task automatic test_random_stream();
        int                  fails;
        logic [OCC_BITS-1:0] occ;
        fails = checks_failed;
        for (int k = 0; k < 200; k++) begin
            random_occ(occ);
            req_mask.push_back(NPORT'($random(seed)));
            req_occ.push_back(occ);
        end
        run_queued(1'b1);
        report_test("random", fails);
    endtask

    initial begin
        seed      = 32'h5601;
        clk       = 1'b0;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        eligible  = '0;
        occupancy = '0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);

        test_idle();
        test_single_port();
        test_ties();
        test_empty();
        test_saturation();
        test_random_stream();

        if (exp_due.size() != 0) begin
            $display("%0d results never came out", exp_due.size());
            checks_failed++;
        end
        $display("checks passed %0d, failed %0d", checks_passed, checks_failed);
        if (checks_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
